// File: src/lsu_pkg.sv
package lsu_pkg;

	typedef logic [31:0] addr_t;   // Byte address from the core
	typedef logic [31:0] data_t;   // Load and store data
	typedef logic [7:0]  byte_t;   // One memory byte
	typedef logic [2:0]  acc_t;    // RISC-V funct3 access code
	typedef logic [3:0]  region_t; // Decoded access target
	typedef logic [6:0]  seg_t;    // Seven-segment pattern, active low, gfedcba
	typedef logic [3:0]  nibble_t; // One hex digit

	// Bit 2 selects zero extension, bits 1:0 give the size
	localparam acc_t ACC_B  = 3'b000; // Signed byte
	localparam acc_t ACC_H  = 3'b001; // Signed halfword
	localparam acc_t ACC_W  = 3'b010; // Word
	localparam acc_t ACC_BU = 3'b100; // Unsigned byte
	localparam acc_t ACC_HU = 3'b101; // Unsigned halfword

	localparam region_t REG_NONE  = 4'd0; // Unmapped
	localparam region_t REG_MEM   = 4'd1; // Data memory
	localparam region_t REG_LEDR  = 4'd2; // Red LEDs
	localparam region_t REG_LEDG  = 4'd3; // Green LEDs
	localparam region_t REG_HEX03 = 4'd4; // Hex digits 3..0
	localparam region_t REG_HEX47 = 4'd5; // Hex digits 7..4
	localparam region_t REG_LCD   = 4'd6; // LCD register
	localparam region_t REG_SW    = 4'd7; // Switch inputs
	localparam region_t REG_KEY   = 4'd8; // Key inputs

	localparam int IO_REGION_W = 12; // 4 KiB per IO region

	localparam addr_t BASE_LEDR  = 32'h1000_0000;
	localparam addr_t BASE_LEDG  = 32'h1000_1000;
	localparam addr_t BASE_HEX03 = 32'h1000_2000;
	localparam addr_t BASE_HEX47 = 32'h1000_3000; // Differs from HEX03 only in bit 12
	localparam addr_t BASE_LCD   = 32'h1000_4000;
	localparam addr_t BASE_KEY   = 32'h1000_5000;
	localparam addr_t BASE_SW    = 32'h1001_0000;

	// Digits 0..F
	localparam seg_t SEG_TABLE [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30,
		7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03,
		7'h46, 7'h21, 7'h06, 7'h0E
	};

endpackage

// File: src/mem_lane_if.sv
`timescale 1ns/10ps

interface mem_lane_if #(
	parameter int DMEM_ADDR_W = 11 // Byte-address bits of the data memory
);

	logic [DMEM_ADDR_W-3:0] lane_addr [4]; // Word index per bank
	lsu_pkg::byte_t         wr_data [4];   // Store byte per bank
	logic                   wr_en [4];     // Write enable per bank
	lsu_pkg::byte_t         rd_data [4];   // Read byte per bank, async

	// Lane mapper side
	modport map (
		output lane_addr,
		output wr_data,
		output wr_en,
		input  rd_data
	);

	// Memory bank side
	modport bank (
		input  lane_addr,
		input  wr_data,
		input  wr_en,
		output rd_data
	);

endinterface

// File: src/lsu_addr_decode.sv
`timescale 1ns/10ps

module lsu_addr_decode #(
	parameter int DMEM_ADDR_W = 11 // Memory occupies 0 .. 2**DMEM_ADDR_W-1
) (
	input  lsu_pkg::addr_t   i_addr,  // Byte address
	output lsu_pkg::region_t o_region // Decoded target
);

	localparam int PAGE_W = 32 - lsu_pkg::IO_REGION_W; // Bits above one IO region

	logic [PAGE_W-1:0] page;    // 4 KiB page of the access
	logic              mem_hit; // All bits above the memory size are zero

	// Page number of an address
	function automatic logic [PAGE_W-1:0] page_of(input lsu_pkg::addr_t a);
		return a[31:lsu_pkg::IO_REGION_W];
	endfunction

	assign page    = page_of(i_addr);
	assign mem_hit = (i_addr[31:DMEM_ADDR_W] == '0);

	always_comb begin
		if (mem_hit) begin
			o_region = lsu_pkg::REG_MEM;
		end else begin
			case (page)
				page_of(lsu_pkg::BASE_LEDR):  o_region = lsu_pkg::REG_LEDR;
				page_of(lsu_pkg::BASE_LEDG):  o_region = lsu_pkg::REG_LEDG;
				page_of(lsu_pkg::BASE_HEX03): o_region = lsu_pkg::REG_HEX03;
				page_of(lsu_pkg::BASE_HEX47): o_region = lsu_pkg::REG_HEX47;
				page_of(lsu_pkg::BASE_LCD):   o_region = lsu_pkg::REG_LCD;
				page_of(lsu_pkg::BASE_KEY):   o_region = lsu_pkg::REG_KEY;
				page_of(lsu_pkg::BASE_SW):    o_region = lsu_pkg::REG_SW;
				default:                      o_region = lsu_pkg::REG_NONE; // Hole in the map
			endcase
		end
	end

endmodule

// File: src/lsu_byte_lanes.sv
`timescale 1ns/10ps

module lsu_byte_lanes #(
	parameter int DMEM_ADDR_W = 11 // Byte-address bits of the data memory
) (
	input  lsu_pkg::addr_t   i_addr,     // Byte address
	input  lsu_pkg::data_t   i_st_data,  // Store data, right aligned
	input  lsu_pkg::acc_t    i_bmask,    // Access code
	input  logic             i_wren,     // Store strobe
	input  lsu_pkg::region_t i_region,   // Decoded target
	output lsu_pkg::data_t   o_mem_data, // Extended load word
	mem_lane_if.map          lanes       // Four byte banks
);

	localparam int WORD_W = DMEM_ADDR_W - 2; // Word index width per bank

	logic [1:0]        offset;     // Byte offset inside the word
	logic [WORD_W-1:0] word_idx;   // Word holding the first byte
	logic [2:0]        acc_bytes;  // Bytes covered: 1, 2 or 4
	logic              mem_store;  // Store that targets memory
	logic              sign_ext;   // Signed load
	lsu_pkg::byte_t    ld_byte [4]; // Loaded bytes in access order

	assign offset    = i_addr[1:0];
	assign word_idx  = i_addr[DMEM_ADDR_W-1:2];
	assign mem_store = i_wren && (i_region == lsu_pkg::REG_MEM);
	assign sign_ext  = ~i_bmask[2]; // Bit 2 set means zero-extend

	// Access size from the funct3 code
	always_comb begin
		case (i_bmask)
			lsu_pkg::ACC_B, lsu_pkg::ACC_BU: acc_bytes = 3'd1;
			lsu_pkg::ACC_H, lsu_pkg::ACC_HU: acc_bytes = 3'd2;
			lsu_pkg::ACC_W:                  acc_bytes = 3'd4;
			default:                         acc_bytes = 3'd4; // Unused codes act as word
		endcase
	end

	for (genvar b = 0; b < 4; b++) begin : g_lane
		logic [1:0] lane_k; // Access byte that lands in bank b

		assign lane_k = 2'(b) - offset; // Bank b holds byte (b - offset) mod 4

		// Banks below the offset hold the bytes that spill into the next word
		assign lanes.lane_addr[b] = word_idx + WORD_W'(2'(b) < offset);
		assign lanes.wr_data[b]   = i_st_data[8*lane_k +: 8];
		assign lanes.wr_en[b]     = mem_store && (3'(lane_k) < acc_bytes); // Only covered bytes

		// Rotate back: access byte b came from bank (offset + b) mod 4
		assign ld_byte[b] = lanes.rd_data[2'(b) + offset];
	end

	// Sign or zero extension by size
	always_comb begin
		case (acc_bytes)
			3'd1: begin
				o_mem_data = {{24{sign_ext & ld_byte[0][7]}}, ld_byte[0]};
			end
			3'd2: begin
				o_mem_data = {{16{sign_ext & ld_byte[1][7]}}, ld_byte[1], ld_byte[0]};
			end
			default: begin
				o_mem_data = {ld_byte[3], ld_byte[2], ld_byte[1], ld_byte[0]}; // Full word
			end
		endcase
	end

endmodule

// File: src/lsu_data_mem.sv
`timescale 1ns/10ps

module lsu_data_mem #(
	parameter int DMEM_ADDR_W = 11 // 2 KiB by default
) (
	input logic      i_clk, // Store clock
	mem_lane_if.bank lanes  // Per-bank address, data, enable and read data
);

	localparam int DEPTH = 2 ** (DMEM_ADDR_W - 2); // Words per bank

	// One byte bank per lane, each addressed on its own
	for (genvar b = 0; b < 4; b++) begin : g_bank
		lsu_pkg::byte_t bank_mem [DEPTH]; // Contents undefined until written

		// Write commits on the rising edge
		always_ff @(posedge i_clk) begin
			if (lanes.wr_en[b]) begin
				bank_mem[lanes.lane_addr[b]] <= lanes.wr_data[b];
			end
		end

		assign lanes.rd_data[b] = bank_mem[lanes.lane_addr[b]]; // Async read
	end

endmodule

// File: src/lsu_io_space.sv
`timescale 1ns/10ps

module lsu_io_space (
	input  logic             i_clk,      // Rising-edge clock
	input  logic             i_reset,    // Async reset, active low
	input  lsu_pkg::addr_t   i_addr,     // Byte address
	input  lsu_pkg::data_t   i_st_data,  // Store data
	input  logic             i_wren,     // Store strobe
	input  lsu_pkg::region_t i_region,   // Decoded target
	input  lsu_pkg::data_t   i_mem_data, // Extended memory load
	input  lsu_pkg::data_t   i_io_sw,    // Switches
	input  logic [1:0]       i_io_key,   // Keys
	output lsu_pkg::data_t   o_ld_data,  // Load result
	output lsu_pkg::data_t   o_io_ledr,  // Red LEDs
	output lsu_pkg::data_t   o_io_ledg,  // Green LEDs
	output lsu_pkg::data_t   o_io_lcd,   // LCD register
	output lsu_pkg::seg_t    o_io_hex0,
	output lsu_pkg::seg_t    o_io_hex1,
	output lsu_pkg::seg_t    o_io_hex2,
	output lsu_pkg::seg_t    o_io_hex3,
	output lsu_pkg::seg_t    o_io_hex4,
	output lsu_pkg::seg_t    o_io_hex5,
	output lsu_pkg::seg_t    o_io_hex6,
	output lsu_pkg::seg_t    o_io_hex7
);

	logic [16:0]      ledr_q;      // 17 red LEDs
	logic [7:0]       ledg_q;      // 8 green LEDs
	lsu_pkg::data_t   lcd_q;       // Full LCD word
	lsu_pkg::nibble_t hex_q [8];   // Digit values
	lsu_pkg::seg_t    hex_seg [8]; // Decoded patterns
	logic             hex_hit;     // Access to either hex group
	logic             hex_grp;     // 0 for digits 3..0, 1 for 7..4
	lsu_pkg::data_t   hex_word;    // Padded patterns of the selected group

	assign hex_hit = (i_region == lsu_pkg::REG_HEX03) || (i_region == lsu_pkg::REG_HEX47);
	assign hex_grp = i_addr[lsu_pkg::IO_REGION_W]; // Bit 12 splits the two hex pages

	always_ff @(posedge i_clk or negedge i_reset) begin
		if (!i_reset) begin
			ledr_q <= '0;
			ledg_q <= '0;
			lcd_q  <= '0;
			for (int d = 0; d < 8; d++) begin
				hex_q[d] <= '0; // Shows 0 on every digit
			end
		end else if (i_wren) begin
			case (i_region)
				lsu_pkg::REG_LEDR: ledr_q <= i_st_data[16:0];
				lsu_pkg::REG_LEDG: ledg_q <= i_st_data[7:0];
				lsu_pkg::REG_LCD:  lcd_q  <= i_st_data;
				default: begin
					if (hex_hit) begin
						for (int d = 0; d < 4; d++) begin
							hex_q[{hex_grp, 2'(d)}] <= i_st_data[4*d +: 4]; // Low nibble to low digit
						end
					end
				end
			endcase
		end
	end

	for (genvar d = 0; d < 8; d++) begin : g_seg
		assign hex_seg[d] = lsu_pkg::SEG_TABLE[hex_q[d]];
	end

	assign o_io_ledr = {15'b0, ledr_q};
	assign o_io_ledg = {24'b0, ledg_q};
	assign o_io_lcd  = lcd_q;
	assign o_io_hex0 = hex_seg[0];
	assign o_io_hex1 = hex_seg[1];
	assign o_io_hex2 = hex_seg[2];
	assign o_io_hex3 = hex_seg[3];
	assign o_io_hex4 = hex_seg[4];
	assign o_io_hex5 = hex_seg[5];
	assign o_io_hex6 = hex_seg[6];
	assign o_io_hex7 = hex_seg[7];

	// Each pattern gets a zero MSB to fill a byte
	always_comb begin
		for (int d = 0; d < 4; d++) begin
			hex_word[8*d +: 8] = {1'b0, hex_seg[{hex_grp, 2'(d)}]};
		end
	end

	// Load return select
	always_comb begin
		case (i_region)
			lsu_pkg::REG_MEM:   o_ld_data = i_mem_data;
			lsu_pkg::REG_SW:    o_ld_data = i_io_sw;
			lsu_pkg::REG_KEY:   o_ld_data = {30'b0, i_io_key};
			lsu_pkg::REG_LEDR:  o_ld_data = o_io_ledr;
			lsu_pkg::REG_LEDG:  o_ld_data = o_io_ledg;
			lsu_pkg::REG_LCD:   o_ld_data = lcd_q;
			lsu_pkg::REG_HEX03: o_ld_data = hex_word;
			lsu_pkg::REG_HEX47: o_ld_data = hex_word;
			default:            o_ld_data = '0; // Unmapped reads as zero
		endcase
	end

endmodule

// File: src/lsu.sv
`timescale 1ns/10ps

module lsu #(
	parameter int DMEM_ADDR_W = 11 // 2 KiB data memory
) (
	input  logic           i_clk,      // Rising-edge clock
	input  logic           i_reset,    // Async reset, active low
	input  lsu_pkg::addr_t i_lsu_addr, // Byte address
	input  lsu_pkg::data_t i_st_data,  // Store data
	input  logic           i_lsu_wren, // Single-cycle store strobe
	input  lsu_pkg::acc_t  i_bmask,    // funct3 access code
	input  lsu_pkg::data_t i_io_sw,    // Switches
	input  logic [1:0]     i_io_key,   // Keys
	output lsu_pkg::data_t o_ld_data,  // Combinational load result
	output lsu_pkg::data_t o_io_ledr,
	output lsu_pkg::data_t o_io_ledg,
	output lsu_pkg::data_t o_io_lcd,
	output lsu_pkg::seg_t  o_io_hex0,
	output lsu_pkg::seg_t  o_io_hex1,
	output lsu_pkg::seg_t  o_io_hex2,
	output lsu_pkg::seg_t  o_io_hex3,
	output lsu_pkg::seg_t  o_io_hex4,
	output lsu_pkg::seg_t  o_io_hex5,
	output lsu_pkg::seg_t  o_io_hex6,
	output lsu_pkg::seg_t  o_io_hex7
);

	lsu_pkg::region_t region;   // Decoded target
	lsu_pkg::data_t   mem_data; // Extended memory load

	mem_lane_if #(.DMEM_ADDR_W(DMEM_ADDR_W)) lanes (); // Mapper to banks

	lsu_addr_decode #(.DMEM_ADDR_W(DMEM_ADDR_W)) u_decode (
		.i_addr   (i_lsu_addr),
		.o_region (region)
	);

	lsu_byte_lanes #(.DMEM_ADDR_W(DMEM_ADDR_W)) u_lanes (
		.i_addr     (i_lsu_addr),
		.i_st_data  (i_st_data),
		.i_bmask    (i_bmask),
		.i_wren     (i_lsu_wren),
		.i_region   (region),
		.o_mem_data (mem_data),
		.lanes      (lanes.map)
	);

	lsu_data_mem #(.DMEM_ADDR_W(DMEM_ADDR_W)) u_mem (
		.i_clk (i_clk),
		.lanes (lanes.bank)
	);

	lsu_io_space u_io (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_addr     (i_lsu_addr),
		.i_st_data  (i_st_data),
		.i_wren     (i_lsu_wren),
		.i_region   (region),
		.i_mem_data (mem_data),
		.i_io_sw    (i_io_sw),
		.i_io_key   (i_io_key),
		.o_ld_data  (o_ld_data),
		.o_io_ledr  (o_io_ledr),
		.o_io_ledg  (o_io_ledg),
		.o_io_lcd   (o_io_lcd),
		.o_io_hex0  (o_io_hex0),
		.o_io_hex1  (o_io_hex1),
		.o_io_hex2  (o_io_hex2),
		.o_io_hex3  (o_io_hex3),
		.o_io_hex4  (o_io_hex4),
		.o_io_hex5  (o_io_hex5),
		.o_io_hex6  (o_io_hex6),
		.o_io_hex7  (o_io_hex7)
	);

endmodule

// File: test/tb_lsu.sv
`timescale 1ns/10ps

module tb_lsu;

	typedef struct {
		lsu_pkg::acc_t  acc;       // Access code
		lsu_pkg::addr_t addr;      // Byte address
		lsu_pkg::data_t data;      // Store data
		bit             wr;        // Store when set
		bit             use_model; // Expected load from the reference model
		lsu_pkg::data_t exp;       // Literal expected load
	} step_t;

	logic           i_clk;
	logic           i_reset;
	lsu_pkg::addr_t i_lsu_addr;
	lsu_pkg::data_t i_st_data;
	logic           i_lsu_wren;
	lsu_pkg::acc_t  i_bmask;
	lsu_pkg::data_t i_io_sw;
	logic [1:0]     i_io_key;
	lsu_pkg::data_t o_ld_data, o_io_ledr, o_io_ledg, o_io_lcd;
	lsu_pkg::seg_t  hex_out [8]; // Hex outputs gathered by digit

	step_t            steps [$];      // Stimulus table
	lsu_pkg::byte_t   ref_mem [2048]; // Byte model of the data memory
	lsu_pkg::data_t   exp_ledr, exp_ledg, exp_lcd;
	lsu_pkg::nibble_t exp_dig [8];
	int               err_count = 0;

	lsu #(.DMEM_ADDR_W(11)) dut (
		.i_clk(i_clk), .i_reset(i_reset), .i_lsu_addr(i_lsu_addr), .i_st_data(i_st_data),
		.i_lsu_wren(i_lsu_wren), .i_bmask(i_bmask), .i_io_sw(i_io_sw), .i_io_key(i_io_key),
		.o_ld_data(o_ld_data), .o_io_ledr(o_io_ledr), .o_io_ledg(o_io_ledg),
		.o_io_lcd(o_io_lcd), .o_io_hex0(hex_out[0]), .o_io_hex1(hex_out[1]),
		.o_io_hex2(hex_out[2]), .o_io_hex3(hex_out[3]), .o_io_hex4(hex_out[4]),
		.o_io_hex5(hex_out[5]), .o_io_hex6(hex_out[6]), .o_io_hex7(hex_out[7])
	);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk; // 8 ns period
	end

	// Watchdog over the whole run
	initial begin
		for (int c = 0; c < 20000; c++) begin
			@(posedge i_clk);
		end
		$display("Run did not finish within 20000 cycles");
		$display("Testbench failed");
		$fatal(1);
	end

	task automatic add(lsu_pkg::acc_t acc, lsu_pkg::addr_t addr, lsu_pkg::data_t data,
			bit wr, bit use_model, lsu_pkg::data_t exp);
		step_t s;
		s = '{acc, addr, data, wr, use_model, exp};
		steps.push_back(s);
	endtask

	task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
		err_count++;
		$display("Fail %s: got %h, expected %h", name, got, exp);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_data(string name, lsu_pkg::data_t got, lsu_pkg::data_t exp);
		if (got !== exp) report_mismatch(name, got, exp);
	endtask

	task automatic check_seg(string name, lsu_pkg::seg_t got, lsu_pkg::seg_t exp);
		if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
	endtask

	// LED and LCD outputs against the shadow registers
	task automatic check_leds();
		check_data("o_io_ledr", o_io_ledr, exp_ledr);
		check_data("o_io_ledg", o_io_ledg, exp_ledg);
		check_data("o_io_lcd", o_io_lcd, exp_lcd);
	endtask

	task automatic check_hex();
		for (int d = 0; d < 8; d++) begin
			check_seg($sformatf("o_io_hex%0d", d), hex_out[d], lsu_pkg::SEG_TABLE[exp_dig[d]]);
		end
	endtask

	// Target of an address, from the memory map
	function automatic lsu_pkg::region_t target_of(lsu_pkg::addr_t a);
		if (a < 32'd2048) return lsu_pkg::REG_MEM;
		case (a[31:12])
			lsu_pkg::BASE_LEDR[31:12]:  return lsu_pkg::REG_LEDR;
			lsu_pkg::BASE_LEDG[31:12]:  return lsu_pkg::REG_LEDG;
			lsu_pkg::BASE_HEX03[31:12]: return lsu_pkg::REG_HEX03;
			lsu_pkg::BASE_HEX47[31:12]: return lsu_pkg::REG_HEX47;
			lsu_pkg::BASE_LCD[31:12]:   return lsu_pkg::REG_LCD;
			lsu_pkg::BASE_KEY[31:12]:   return lsu_pkg::REG_KEY;
			lsu_pkg::BASE_SW[31:12]:    return lsu_pkg::REG_SW;
			default:                    return lsu_pkg::REG_NONE;
		endcase
	endfunction

	function automatic int size_of(lsu_pkg::acc_t acc);
		return (acc[1:0] == 2'd0) ? 1 : (acc[1:0] == 2'd1) ? 2 : 4;
	endfunction

	// Commit a store into the model and the shadow registers
	task automatic apply_store(lsu_pkg::addr_t a, lsu_pkg::data_t d, lsu_pkg::acc_t acc);
		int grp;
		grp = (target_of(a) == lsu_pkg::REG_HEX47) ? 4 : 0;
		case (target_of(a))
			lsu_pkg::REG_MEM: begin
				for (int k = 0; k < size_of(acc); k++) begin
					ref_mem[(a + k) % 2048] = d[8*k +: 8]; // Wraps at the top
				end
			end
			lsu_pkg::REG_LEDR: exp_ledr = {15'b0, d[16:0]};
			lsu_pkg::REG_LEDG: exp_ledg = {24'b0, d[7:0]};
			lsu_pkg::REG_LCD:  exp_lcd = d;
			lsu_pkg::REG_HEX03, lsu_pkg::REG_HEX47: begin
				for (int k = 0; k < 4; k++) exp_dig[grp + k] = d[4*k +: 4];
			end
			default: ; // Inputs and holes ignore stores
		endcase
	endtask

	function automatic lsu_pkg::data_t model_load(lsu_pkg::addr_t a, lsu_pkg::acc_t acc);
		lsu_pkg::data_t w;
		int n;
		int grp;
		n = size_of(acc);
		grp = (target_of(a) == lsu_pkg::REG_HEX47) ? 4 : 0;
		w = '0;
		case (target_of(a))
			lsu_pkg::REG_MEM: begin
				for (int k = 0; k < n; k++) w[8*k +: 8] = ref_mem[(a + k) % 2048];
				if (!acc[2] && n < 4 && w[8*n-1]) begin
					for (int b = 8 * n; b < 32; b++) w[b] = 1'b1; // Sign fill
				end
			end
			lsu_pkg::REG_SW:   w = i_io_sw;
			lsu_pkg::REG_KEY:  w = {30'b0, i_io_key};
			lsu_pkg::REG_LEDR: w = exp_ledr;
			lsu_pkg::REG_LEDG: w = exp_ledg;
			lsu_pkg::REG_LCD:  w = exp_lcd;
			lsu_pkg::REG_HEX03, lsu_pkg::REG_HEX47: begin
				for (int k = 0; k < 4; k++) w[8*k +: 8] = {1'b0, lsu_pkg::SEG_TABLE[exp_dig[grp + k]]};
			end
			default: w = '0;
		endcase
		return w;
	endfunction

	task automatic build_table();
		add(lsu_pkg::ACC_W, 32'h000, 32'h8123_45F6, 1, 0, 0); // Aligned word
		for (int a = 0; a < 4; a++) begin
			add(lsu_pkg::ACC_B, a, 0, 0, 1, 0);
			add(lsu_pkg::ACC_BU, a, 0, 0, 1, 0);
		end
		for (int a = 0; a < 3; a++) begin
			add(lsu_pkg::ACC_H, a, 0, 0, 1, 0);
			add(lsu_pkg::ACC_HU, a, 0, 0, 1, 0);
		end
		add(lsu_pkg::ACC_W, 32'h000, 0, 0, 1, 0);
		add(lsu_pkg::ACC_W, 32'h105, 32'hC0DE_F08D, 1, 0, 0); // Misaligned word
		add(lsu_pkg::ACC_W, 32'h105, 0, 0, 1, 0);
		for (int a = 32'h105; a < 32'h109; a++) add(lsu_pkg::ACC_B, a, 0, 0, 1, 0);
		add(lsu_pkg::ACC_HU, 32'h107, 0, 0, 1, 0);
		add(lsu_pkg::ACC_W, 32'h403, 32'h9E37_79B9, 1, 0, 0); // Word at offset 3
		add(lsu_pkg::ACC_W, 32'h403, 0, 0, 1, 0);
		add(lsu_pkg::ACC_H, 32'h405, 0, 0, 1, 0);
		add(lsu_pkg::ACC_BU, 32'h403, 0, 0, 1, 0);
		for (int a = 0; a < 4; a++) begin
			add(lsu_pkg::ACC_H, 32'h200 + 9 * a, 32'h5A5A_8000 + 32'h111 * a, 1, 0, 0);
			add(lsu_pkg::ACC_H, 32'h200 + 9 * a, 0, 0, 1, 0);
			add(lsu_pkg::ACC_HU, 32'h200 + 9 * a, 0, 0, 1, 0);
		end
		for (int a = 0; a < 4; a++) begin
			add(lsu_pkg::ACC_B, 32'h300 + a, 32'hFFFF_FF80 + 32'h21 * a, 1, 0, 0);
			add(lsu_pkg::ACC_B, 32'h300 + a, 0, 0, 1, 0);
		end
		add(lsu_pkg::ACC_W, 32'h300, 0, 0, 1, 0);
		add(lsu_pkg::ACC_W, 32'h7FE, 32'h1357_9BDF, 1, 0, 0); // Wraps to address 0
		add(lsu_pkg::ACC_W, 32'h7FE, 0, 0, 1, 0);
		add(lsu_pkg::ACC_HU, 32'h000, 0, 0, 1, 0);
		add(lsu_pkg::ACC_W, lsu_pkg::BASE_LEDR, 32'hFFFF_FFFF, 1, 0, 0);
		add(lsu_pkg::ACC_W, lsu_pkg::BASE_LEDR, 0, 0, 0, 32'h0001_FFFF);
		add(lsu_pkg::ACC_W, lsu_pkg::BASE_LEDG, 32'hABCD_1234, 1, 0, 0);
		add(lsu_pkg::ACC_W, lsu_pkg::BASE_LEDG, 0, 0, 0, 32'h0000_0034);
		add(lsu_pkg::ACC_W, lsu_pkg::BASE_LCD, 32'hDEAD_BEEF, 1, 0, 0);
		add(lsu_pkg::ACC_W, lsu_pkg::BASE_LCD, 0, 0, 0, 32'hDEAD_BEEF);
		add(lsu_pkg::ACC_W, lsu_pkg::BASE_HEX03 + 4, 32'h0000_1234, 1, 0, 0);
		add(lsu_pkg::ACC_W, lsu_pkg::BASE_HEX03, 0, 0, 1, 0);
		add(lsu_pkg::ACC_H, lsu_pkg::BASE_HEX47, 32'hFFFF_ABCD, 1, 0, 0); // Any code writes
		add(lsu_pkg::ACC_W, lsu_pkg::BASE_HEX47, 0, 0, 1, 0);
		add(lsu_pkg::ACC_W, lsu_pkg::BASE_SW, 0, 0, 1, 0);
		add(lsu_pkg::ACC_W, lsu_pkg::BASE_KEY, 0, 0, 0, 32'h0000_0002);
		add(lsu_pkg::ACC_W, lsu_pkg::BASE_SW, 32'hFFFF_FFFF, 1, 0, 0); // Ignored stores
		add(lsu_pkg::ACC_W, lsu_pkg::BASE_KEY, 32'hFFFF_FFFF, 1, 0, 0);
		add(lsu_pkg::ACC_W, 32'h0000_0800, 32'hFFFF_FFFF, 1, 0, 0);
		add(lsu_pkg::ACC_W, 32'h2000_0000, 32'hFFFF_FFFF, 1, 0, 0);
		add(lsu_pkg::ACC_W, 32'h000, 0, 0, 1, 0);
		add(lsu_pkg::ACC_W, 32'h2000_0000, 0, 0, 0, 32'h0);
	endtask

	initial begin
		bit done;
		void'($urandom(32'hcec8_b095));
		i_reset = 1'b0;
		i_lsu_addr = 32'h2000_0000; // Unmapped during reset
		i_st_data = '0;
		i_lsu_wren = 1'b0;
		i_bmask = lsu_pkg::ACC_W;
		i_io_sw = $urandom();
		i_io_key = 2'b10;
		exp_ledr = '0;
		exp_ledg = '0;
		exp_lcd = '0;
		for (int d = 0; d < 8; d++) exp_dig[d] = '0;
		build_table();
		repeat (16) @(posedge i_clk);
		i_reset <= 1'b1;
		done = 0;
		for (int c = 0; c < 8 && !done; c++) begin // Wait for outputs to settle
			@(negedge i_clk);
			done = (o_io_ledr === '0) && (hex_out[0] === lsu_pkg::SEG_TABLE[0]);
		end
		if (!done) begin
			$display("Outputs did not come out of reset");
			$display("Testbench failed");
			$fatal(1);
		end
		check_leds();
		check_hex();
		check_data("o_ld_data", o_ld_data, 32'h0);
		foreach (steps[i]) begin
			@(posedge i_clk);
			i_bmask <= steps[i].acc;
			i_lsu_addr <= steps[i].addr;
			i_st_data <= steps[i].data;
			i_lsu_wren <= steps[i].wr;
			@(negedge i_clk);
			if (!steps[i].wr) begin
				check_data("o_ld_data", o_ld_data, steps[i].use_model ?
					model_load(steps[i].addr, steps[i].acc) : steps[i].exp);
			end else begin
				@(posedge i_clk);
				i_lsu_wren <= 1'b0; // Single-cycle strobe
				apply_store(steps[i].addr, steps[i].data, steps[i].acc);
				@(negedge i_clk);
			end
			check_leds();
			check_hex();
		end
		if (err_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: sources.f
src/lsu_pkg.sv
src/mem_lane_if.sv
src/lsu_addr_decode.sv
src/lsu_byte_lanes.sv
src/lsu_data_mem.sv
src/lsu_io_space.sv
src/lsu.sv
test/tb_lsu.sv

// File: Bender.yml
package:
  name: lsu
  authors: []

sources:
  - src/lsu_pkg.sv
  - src/mem_lane_if.sv
  - src/lsu_addr_decode.sv
  - src/lsu_byte_lanes.sv
  - src/lsu_data_mem.sv
  - src/lsu_io_space.sv
  - src/lsu.sv
  - target: simulation
    files:
      - test/tb_lsu.sv
